// ==== tb_tpl_adc_core.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "tpl_adc_defs.svh"

module tb_tpl_adc_core;

  localparam int NCH = `TPL_NUM_CHANNELS;
  localparam int SPB = `TPL_SAMPLES_PER_BEAT;
  localparam int RES = `TPL_CONVERTER_RESOLUTION;
  localparam int DMA = `TPL_DMA_BITS_PER_SAMPLE;
  localparam int LANE_BITS = $bits(tpl_adc_pkg::lane_word_t);
  localparam int FMT_BITS = $bits(tpl_adc_pkg::fmt_group_t);
  localparam int SEL_BITS = $bits(tpl_adc_pkg::pn_sel_t);
  localparam int CLK_PERIOD = 100;

  // Phase lengths in beats, the watchdog is derived from their sum
  localparam int RESET_CYCLES = 3;
  localparam int RANDOM_BEATS = 200;
  localparam int LOCK_BEATS = 60;
  localparam int ERROR_BEATS = 80;
  localparam int LOSS_BEATS = 8;
  localparam int OFF_BEATS = 30;
  localparam int SYNC_BEATS = 200;
  localparam int FLUSH_CYCLES = 6;
  localparam int TOTAL_CYCLES = RESET_CYCLES + RANDOM_BEATS + LOCK_BEATS + ERROR_BEATS +
                                LOSS_BEATS + OFF_BEATS + SYNC_BEATS + 6 * FLUSH_CYCLES + 2;
  localparam int TIMEOUT_NS = (TOTAL_CYCLES + 50) * CLK_PERIOD;

  logic                          clk;
  logic                          arst_n;
  logic                          link_valid;
  tpl_adc_pkg::link_beat_t       link_data;
  logic [NCH-1:0]                dfmt_enable;
  logic [NCH-1:0]                dfmt_sign_extend;
  logic [NCH-1:0]                dfmt_type;
  logic [NCH*SEL_BITS-1:0]       pn_seq_sel;
  logic [NCH-1:0]                pn_err;
  logic [NCH-1:0]                pn_oos;
  logic [NCH-1:0]                adc_valid;
  logic [NCH*FMT_BITS-1:0]       adc_data;
  logic                          adc_sync_status;
  logic                          adc_rst_sync;
  logic                          adc_ext_sync_arm;
  logic                          adc_ext_sync_disarm;
  logic                          adc_sync_in;
  logic                          adc_sync_manual_req;

  // Random source and bookkeeping
  logic [31:0] lcg_state = 32'h1052_620c;
  int          checks = 0;
  int          errors = 0;
  logic        sync_random = 1'b0;
  logic        pn_err_seen = 1'b0;
  logic        armed_seen = 1'b0;
  tpl_adc_pkg::raw_sample_t gen_last [NCH];

  // Reference model state, one entry per pipeline stage of the timing rules
  tpl_adc_pkg::raw_sample_t    m_raw [NCH][SPB];
  logic                        m_raw_valid;
  tpl_adc_pkg::fmt_group_t     m_fmt [NCH];
  logic                        m_fmt_chk;
  tpl_adc_pkg::fmt_group_t     exp_data [NCH];
  logic                        exp_data_chk;
  logic                        exp_valid;
  logic [NCH-1:0]              exp_pn_err;
  tpl_adc_pkg::pn_state_t      m_pn_state [NCH];
  int                          m_good [NCH];
  int                          m_bad [NCH];
  tpl_adc_pkg::raw_sample_t    m_prev [NCH];
  tpl_adc_pkg::capture_state_t m_cap;

  tpl_adc_core uut (
    .clk                 (clk),
    .arst_n              (arst_n),
    .link_valid          (link_valid),
    .link_data           (link_data),
    .dfmt_enable         (dfmt_enable),
    .dfmt_sign_extend    (dfmt_sign_extend),
    .dfmt_type           (dfmt_type),
    .pn_seq_sel          (pn_seq_sel),
    .pn_err              (pn_err),
    .pn_oos              (pn_oos),
    .adc_valid           (adc_valid),
    .adc_data            (adc_data),
    .adc_sync_status     (adc_sync_status),
    .adc_rst_sync        (adc_rst_sync),
    .adc_ext_sync_arm    (adc_ext_sync_arm),
    .adc_ext_sync_disarm (adc_ext_sync_disarm),
    .adc_sync_in         (adc_sync_in),
    .adc_sync_manual_req (adc_sync_manual_req)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  // ********************
  // Helpers
  // ********************

  // Two LCG steps per call, keeping only the upper halves which are the better bits
  function automatic logic [31:0] rand_next();
    logic [15:0] hi;
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    hi = lcg_state[31:16];
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {hi, lcg_state[31:16]};
  endfunction

  // Next expected sample, PN9 as a bit stream b[n] = b[n-9] ^ b[n-5], or a ramp
  function automatic tpl_adc_pkg::raw_sample_t pattern_next(input tpl_adc_pkg::pn_sel_t sel,
                                                            input tpl_adc_pkg::raw_sample_t prev);
    logic [RES+8:0]           bits;
    tpl_adc_pkg::raw_sample_t res;
    if (sel == 4'd1) begin
      return prev + 1'b1;
    end
    // The newest stream bit is the LSB of the previous sample
    for (int n = 0; n < 9; n++) begin
      bits[n] = prev[8-n];
    end
    for (int n = 9; n < 9 + RES; n++) begin
      bits[n] = bits[n-9] ^ bits[n-5];
    end
    for (int i = 0; i < RES; i++) begin
      res[RES-1-i] = bits[9+i];
    end
    return res;
  endfunction

  function automatic logic [DMA-1:0] fmt_sample(input tpl_adc_pkg::raw_sample_t raw,
                                               input logic en, input logic sx, input logic ty);
    tpl_adc_pkg::raw_sample_t conv;
    conv = raw;
    // Offset binary becomes two's complement when the MSB flips
    if (en && !ty) begin
      conv[RES-1] = ~raw[RES-1];
    end
    if (en && sx) begin
      return {{(DMA-RES){conv[RES-1]}}, conv};
    end
    return {{(DMA-RES){1'b0}}, conv};
  endfunction

  // Octet 0 is the high octet of sample 0, the 2 tail bits are random filler
  function automatic tpl_adc_pkg::lane_word_t encode_lane(input tpl_adc_pkg::raw_sample_t s0,
                                                         input tpl_adc_pkg::raw_sample_t s1,
                                                         input logic [3:0] tails);
    logic [15:0] w0;
    logic [15:0] w1;
    w0 = {s0, tails[1:0]};
    w1 = {s1, tails[3:2]};
    return {w1[7:0], w1[15:8], w0[7:0], w0[15:8]};
  endfunction

  // Channel 0 carries PN9 and channel 1 a ramp
  function automatic tpl_adc_pkg::pn_sel_t chan_pattern(input int c);
    return (c == 0) ? 4'd0 : 4'd1;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("ERROR at %0t ns: %s expected 0x%0h, actual 0x%0h", $time, name, expected, actual);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("At %0t ns: %s", $time, what);
    end
  endtask

  // ********************
  // Reference model
  // ********************

  task automatic model_reset();
    m_raw_valid  = 1'b0;
    m_fmt_chk    = 1'b0;
    exp_data_chk = 1'b0;
    exp_valid    = 1'b0;
    exp_pn_err   = '0;
    m_cap        = tpl_adc_pkg::CAPTURE_RUN;
    for (int c = 0; c < NCH; c++) begin
      m_pn_state[c] = tpl_adc_pkg::PN_OOS;
      m_good[c] = 0;
      m_bad[c] = 0;
      m_prev[c] = '0;
      for (int s = 0; s < SPB; s++) begin
        m_raw[c][s] = '0;
      end
    end
  endtask

  task automatic model_step();
    tpl_adc_pkg::pn_sel_t     sel;
    tpl_adc_pkg::raw_sample_t ref_smp;
    tpl_adc_pkg::lane_word_t  lane;
    logic [7:0]               hi_oct;
    logic [7:0]               lo_oct;
    logic                     good_pair;
    logic                     any_bad;
    logic                     was_locked;
    // The sync state moves first because the output valid is gated by the new state
    if (m_cap == tpl_adc_pkg::CAPTURE_RUN && adc_ext_sync_arm) begin
      m_cap = tpl_adc_pkg::CAPTURE_ARMED;
    end else if (m_cap == tpl_adc_pkg::CAPTURE_ARMED &&
                 (adc_ext_sync_disarm || adc_sync_in || adc_sync_manual_req)) begin
      m_cap = tpl_adc_pkg::CAPTURE_RUN;
    end
    exp_valid    = m_fmt_chk && (m_cap == tpl_adc_pkg::CAPTURE_RUN);
    exp_data_chk = m_fmt_chk;
    for (int c = 0; c < NCH; c++) begin
      exp_data[c] = m_fmt[c];
      sel = pn_seq_sel[c*SEL_BITS +: SEL_BITS];
      exp_pn_err[c] = 1'b0;
      if (sel > 4'd1) begin
        m_pn_state[c] = tpl_adc_pkg::PN_OOS;
        m_good[c] = 0;
        m_bad[c] = 0;
      end else if (m_raw_valid) begin
        was_locked = (m_pn_state[c] == tpl_adc_pkg::PN_LOCKED);
        any_bad = 1'b0;
        ref_smp = m_prev[c];
        // Pairs are counted in sample order, so lock may be reached mid beat
        for (int s = 0; s < SPB; s++) begin
          good_pair = (pattern_next(sel, ref_smp) == m_raw[c][s]);
          ref_smp = m_raw[c][s];
          any_bad = any_bad || !good_pair;
          if (good_pair) begin
            m_bad[c] = 0;
            if (m_pn_state[c] == tpl_adc_pkg::PN_OOS) begin
              m_good[c]++;
              if (m_good[c] == `TPL_PN_LOCK_COUNT) begin
                m_pn_state[c] = tpl_adc_pkg::PN_LOCKED;
                m_good[c] = 0;
              end
            end
          end else begin
            m_good[c] = 0;
            if (m_pn_state[c] == tpl_adc_pkg::PN_LOCKED) begin
              m_bad[c]++;
              if (m_bad[c] == `TPL_PN_LOSS_COUNT) begin
                m_pn_state[c] = tpl_adc_pkg::PN_OOS;
                m_bad[c] = 0;
              end
            end
          end
        end
        exp_pn_err[c] = was_locked && any_bad;
      end
      if (m_raw_valid) begin
        m_prev[c] = m_raw[c][SPB-1];
      end
      // Format settings are taken when the raw samples reach the channel
      for (int s = 0; s < SPB; s++) begin
        m_fmt[c][s*DMA +: DMA] = fmt_sample(m_raw[c][s], dfmt_enable[c], dfmt_sign_extend[c],
                                            dfmt_type[c]);
      end
    end
    m_fmt_chk = m_raw_valid;
    m_raw_valid = link_valid;
    for (int c = 0; c < NCH; c++) begin
      lane = link_data[c*LANE_BITS +: LANE_BITS];
      for (int s = 0; s < SPB; s++) begin
        // Octet 2s is the high octet of sample s, octet 2s+1 holds its low bits and the tail
        hi_oct = lane[(2*s)*8 +: 8];
        lo_oct = lane[(2*s+1)*8 +: 8];
        m_raw[c][s] = {hi_oct, lo_oct[7:2]};
      end
    end
  endtask

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      model_reset();
    end else begin
      model_step();
    end
  end

  // Outputs are compared in the middle of the cycle, well away from the clock edge
  always @(negedge clk) begin
    for (int c = 0; c < NCH; c++) begin
      check_value($sformatf("adc_valid[%0d]", c), exp_valid, adc_valid[c]);
      check_value($sformatf("pn_err[%0d]", c), exp_pn_err[c], pn_err[c]);
      check_value($sformatf("pn_oos[%0d]", c), m_pn_state[c] == tpl_adc_pkg::PN_OOS, pn_oos[c]);
      if (exp_data_chk) begin
        check_value($sformatf("adc_data[%0d]", c), exp_data[c],
                    adc_data[c*FMT_BITS +: FMT_BITS]);
      end
    end
    check_value("adc_sync_status", m_cap == tpl_adc_pkg::CAPTURE_ARMED, adc_sync_status);
    check_value("adc_rst_sync", m_cap == tpl_adc_pkg::CAPTURE_ARMED, adc_rst_sync);
    check_true(!(adc_sync_status && (adc_valid != '0)), "adc_valid was high while armed");
    if (pn_err != '0) begin
      pn_err_seen = 1'b1;
    end
    if (adc_sync_status) begin
      armed_seen = 1'b1;
    end
  end

  // ********************
  // Stimulus
  // ********************

  task automatic drive_beat(input logic valid, input tpl_adc_pkg::link_beat_t data);
    logic [31:0] r;
    r = rand_next();
    @(posedge clk);
    link_valid       <= valid;
    link_data        <= data;
    dfmt_enable      <= r[0 +: NCH];
    dfmt_sign_extend <= r[4 +: NCH];
    dfmt_type        <= r[8 +: NCH];
    if (sync_random) begin
      adc_ext_sync_arm    <= (r[14:12] == 3'd0);
      adc_ext_sync_disarm <= (r[18:15] == 4'd0);
      adc_sync_in         <= (r[22:19] == 4'd0);
      adc_sync_manual_req <= (r[26:23] == 4'd0);
    end else begin
      adc_ext_sync_arm    <= 1'b0;
      adc_ext_sync_disarm <= 1'b0;
      adc_sync_in         <= 1'b0;
      adc_sync_manual_req <= 1'b0;
    end
  endtask

  task automatic random_beats(input int n, input logic force_valid);
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      r = rand_next();
      drive_beat(force_valid || (r[1:0] != 2'b00), {rand_next(), rand_next()});
    end
  endtask

  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      drive_beat(1'b0, {rand_next(), rand_next()});
    end
  endtask

  // Pattern beats with random gaps, the generators only advance on valid beats
  task automatic pattern_beats(input int n, input logic inject);
    logic [31:0]              r;
    logic                     valid;
    logic                     hit;
    logic                     hit_prev;
    tpl_adc_pkg::raw_sample_t s0;
    tpl_adc_pkg::raw_sample_t s1;
    tpl_adc_pkg::raw_sample_t flip;
    tpl_adc_pkg::link_beat_t  beat;
    hit_prev = 1'b0;
    for (int i = 0; i < n; i++) begin
      r = rand_next();
      valid = (r[1:0] != 2'b00);
      beat = {rand_next(), rand_next()};
      if (valid) begin
        // Injections never touch two valid beats in a row, so lock must hold
        hit = inject && !hit_prev && (r[12:10] == 3'd0);
        hit_prev = hit;
        for (int c = 0; c < NCH; c++) begin
          s0 = pattern_next(chan_pattern(c), gen_last[c]);
          s1 = pattern_next(chan_pattern(c), s0);
          gen_last[c] = s1;
          if (hit && int'(r[13]) == c) begin
            flip = '0;
            flip[r[7:4] % RES] = 1'b1;
            s0 = s0 ^ flip;
          end
          beat[c*LANE_BITS +: LANE_BITS] = encode_lane(s0, s1, r[19:16]);
        end
      end
      drive_beat(valid, beat);
    end
  endtask

  // ********************
  // Test sequence
  // ********************

  initial begin
    logic [31:0] r;
    arst_n              = 1'b0;
    link_valid          = 1'b0;
    link_data           = '0;
    dfmt_enable         = '0;
    dfmt_sign_extend    = '0;
    dfmt_type           = '0;
    pn_seq_sel          = {4'd1, 4'd0};
    adc_ext_sync_arm    = 1'b0;
    adc_ext_sync_disarm = 1'b0;
    adc_sync_in         = 1'b0;
    adc_sync_manual_req = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    arst_n <= 1'b1;

    // Reset values right after release
    @(negedge clk);
    check_value("adc_valid after reset", '0, adc_valid);
    check_value("pn_err after reset", '0, pn_err);
    check_value("pn_oos after reset", {NCH{1'b1}}, pn_oos);
    check_value("adc_sync_status after reset", 1'b0, adc_sync_status);
    check_value("adc_rst_sync after reset", 1'b0, adc_rst_sync);

    random_beats(RANDOM_BEATS, 1'b0);
    idle_cycles(FLUSH_CYCLES);

    // PN9 on channel 0 and a ramp on channel 1, seeded away from the all zero state
    r = rand_next();
    gen_last[0] = r[RES-1:0] | 14'h1;
    gen_last[1] = r[31:32-RES];
    pn_err_seen = 1'b0;
    pattern_beats(LOCK_BEATS, 1'b0);
    idle_cycles(FLUSH_CYCLES);
    check_true(pn_oos == '0, "pn_oos did not clear during the lock phase");
    check_true(!pn_err_seen, "pn_err pulsed while the patterns were locking");

    pn_err_seen = 1'b0;
    pattern_beats(ERROR_BEATS, 1'b1);
    idle_cycles(FLUSH_CYCLES);
    check_true(pn_oos == '0, "single bad samples made the monitor lose lock");
    check_true(pn_err_seen, "no pn_err pulse was seen for the injected bad samples");

    random_beats(LOSS_BEATS, 1'b1);
    idle_cycles(FLUSH_CYCLES);
    check_true(pn_oos == {NCH{1'b1}}, "pn_oos did not rise after consecutive bad pairs");

    // Selector values above 1 switch checking off
    @(posedge clk);
    pn_seq_sel <= '1;
    pn_err_seen = 1'b0;
    pattern_beats(OFF_BEATS, 1'b1);
    idle_cycles(FLUSH_CYCLES);
    check_true(pn_oos == {NCH{1'b1}}, "pn_oos dropped while checking was off");
    check_true(!pn_err_seen, "pn_err pulsed while checking was off");

    sync_random = 1'b1;
    random_beats(SYNC_BEATS, 1'b0);
    sync_random = 1'b0;
    idle_cycles(FLUSH_CYCLES);
    check_true(armed_seen, "the sync state machine was never armed");

    @(negedge clk);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Watchdog sized from the phase lengths plus a margin of 50 cycles
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tpl_adc_core.f ====
+incdir+.
tpl_adc_pkg.sv
tpl_deframer.sv
tpl_pn_monitor.sv
tpl_channel.sv
tpl_capture_sync.sv
tpl_adc_core.sv
tb_tpl_adc_core.sv

// ==== tpl_adc_core.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "tpl_adc_defs.svh"

module tpl_adc_core (
  input  wire                                clk,
  input  wire                                arst_n,
  input  wire                                link_valid,
  input  tpl_adc_pkg::link_beat_t            link_data,
  input  wire [`TPL_NUM_CHANNELS-1:0]        dfmt_enable,
  input  wire [`TPL_NUM_CHANNELS-1:0]        dfmt_sign_extend,
  input  wire [`TPL_NUM_CHANNELS-1:0]        dfmt_type,
  input  wire [`TPL_NUM_CHANNELS*$bits(tpl_adc_pkg::pn_sel_t)-1:0] pn_seq_sel,
  output logic [`TPL_NUM_CHANNELS-1:0]       pn_err,
  output logic [`TPL_NUM_CHANNELS-1:0]       pn_oos,
  output logic [`TPL_NUM_CHANNELS-1:0]       adc_valid,
  output logic [`TPL_NUM_CHANNELS*$bits(tpl_adc_pkg::fmt_group_t)-1:0] adc_data,
  output logic                               adc_sync_status,
  output logic                               adc_rst_sync,
  input  wire                                adc_ext_sync_arm,
  input  wire                                adc_ext_sync_disarm,
  input  wire                                adc_sync_in,
  input  wire                                adc_sync_manual_req
);

  localparam int RAW_BITS = $bits(tpl_adc_pkg::raw_group_t);
  localparam int FMT_BITS = $bits(tpl_adc_pkg::fmt_group_t);
  localparam int SEL_BITS = $bits(tpl_adc_pkg::pn_sel_t);

  logic [`TPL_NUM_CHANNELS*RAW_BITS-1:0] raw_data;
  logic [`TPL_NUM_CHANNELS*FMT_BITS-1:0] fmt_data;
  logic                                  link_valid_d;

  // Valid delayed to line up with the deframer output for the channels
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      link_valid_d <= 1'b0;
    end else begin
      link_valid_d <= link_valid;
    end
  end

  tpl_deframer i_deframer (
    .clk       (clk),
    .arst_n    (arst_n),
    .link_data (link_data),
    .raw_data  (raw_data)
  );

  // One channel per converter, each with its own format and pattern settings
  for (genvar i = 0; i < `TPL_NUM_CHANNELS; i++) begin : g_channel
    tpl_channel i_channel (
      .clk              (clk),
      .arst_n           (arst_n),
      .link_valid       (link_valid_d),
      .raw_data         (raw_data[i*RAW_BITS +: RAW_BITS]),
      .dfmt_enable      (dfmt_enable[i]),
      .dfmt_sign_extend (dfmt_sign_extend[i]),
      .dfmt_type        (dfmt_type[i]),
      .pn_seq_sel       (pn_seq_sel[i*SEL_BITS +: SEL_BITS]),
      .fmt_data         (fmt_data[i*FMT_BITS +: FMT_BITS]),
      .pn_err           (pn_err[i]),
      .pn_oos           (pn_oos[i])
    );
  end

  // The capture stage keeps its own valid pipeline from the undelayed strobe
  tpl_capture_sync i_capture_sync (
    .clk                 (clk),
    .arst_n              (arst_n),
    .link_valid          (link_valid),
    .fmt_data            (fmt_data),
    .adc_ext_sync_arm    (adc_ext_sync_arm),
    .adc_ext_sync_disarm (adc_ext_sync_disarm),
    .adc_sync_in         (adc_sync_in),
    .adc_sync_manual_req (adc_sync_manual_req),
    .adc_valid           (adc_valid),
    .adc_data            (adc_data),
    .adc_sync_status     (adc_sync_status),
    .adc_rst_sync        (adc_rst_sync)
  );

endmodule

`default_nettype wire

// ==== tpl_adc_defs.svh ====
`ifndef TPL_ADC_DEFS_SVH
`define TPL_ADC_DEFS_SVH

// ********************
// Link geometry
// ********************

// Lanes in the JESD204 link
`define TPL_NUM_LANES 2

// Octets each lane delivers per beat
`define TPL_OCTETS_PER_BEAT 4

// ********************
// Converter geometry
// ********************

// Converters, one per lane in this mapping
`define TPL_NUM_CHANNELS 2

// Samples each converter delivers per beat
`define TPL_SAMPLES_PER_BEAT 2

// Raw resolution of one converter sample
`define TPL_CONVERTER_RESOLUTION 14

// Width of one formatted sample towards the DMA
`define TPL_DMA_BITS_PER_SAMPLE 16

// Consecutive good pairs needed before the PN monitor declares lock
`define TPL_PN_LOCK_COUNT 16

// Consecutive bad pairs that drop the PN monitor back out of sync
`define TPL_PN_LOSS_COUNT 8

`endif

// ==== tpl_adc_pkg.sv ====
`default_nettype none

`include "tpl_adc_defs.svh"

package tpl_adc_pkg;

  // ********************
  // Data widths
  // ********************

  // One full link beat covering every lane
  typedef logic [`TPL_NUM_LANES*`TPL_OCTETS_PER_BEAT*8-1:0] link_beat_t;

  // The part of a beat carried by a single lane
  typedef logic [`TPL_OCTETS_PER_BEAT*8-1:0] lane_word_t;

  // One raw converter sample
  typedef logic [`TPL_CONVERTER_RESOLUTION-1:0] raw_sample_t;

  // All raw samples of one channel in one beat, sample 0 in the low bits
  typedef logic [`TPL_SAMPLES_PER_BEAT*`TPL_CONVERTER_RESOLUTION-1:0] raw_group_t;

  // All formatted samples of one channel in one beat
  typedef logic [`TPL_SAMPLES_PER_BEAT*`TPL_DMA_BITS_PER_SAMPLE-1:0] fmt_group_t;

  // Test pattern selector, 0 is PN9, 1 is ramp and the rest disable checking
  typedef logic [3:0] pn_sel_t;

  // ********************
  // State machines
  // ********************

  typedef enum logic {PN_OOS = 1'b0, PN_LOCKED = 1'b1} pn_state_t;

  typedef enum logic {CAPTURE_RUN = 1'b0, CAPTURE_ARMED = 1'b1} capture_state_t;

endpackage

`default_nettype wire

// ==== tpl_capture_sync.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "tpl_adc_defs.svh"

module tpl_capture_sync (
  input  wire                            clk,
  input  wire                            arst_n,
  input  wire                            link_valid,
  input  wire [`TPL_NUM_CHANNELS*$bits(tpl_adc_pkg::fmt_group_t)-1:0] fmt_data,
  input  wire                            adc_ext_sync_arm,
  input  wire                            adc_ext_sync_disarm,
  input  wire                            adc_sync_in,
  input  wire                            adc_sync_manual_req,
  output logic [`TPL_NUM_CHANNELS-1:0]   adc_valid,
  output logic [`TPL_NUM_CHANNELS*$bits(tpl_adc_pkg::fmt_group_t)-1:0] adc_data,
  output logic                           adc_sync_status,
  output logic                           adc_rst_sync
);

  tpl_adc_pkg::capture_state_t state;
  tpl_adc_pkg::capture_state_t state_next;
  logic                        sync_in;
  logic                        valid_d1;
  logic                        valid_d2;

  // Either the external sync pin or a software request releases the capture
  assign sync_in = adc_sync_in | adc_sync_manual_req;

  // ********************
  // Sync state machine
  // ********************

  always_comb begin
    state_next = state;
    case (state)
      tpl_adc_pkg::CAPTURE_RUN: begin
        if (adc_ext_sync_arm) begin
          state_next = tpl_adc_pkg::CAPTURE_ARMED;
        end
      end
      tpl_adc_pkg::CAPTURE_ARMED: begin
        if (adc_ext_sync_disarm || sync_in) begin
          state_next = tpl_adc_pkg::CAPTURE_RUN;
        end
      end
      default: begin
        state_next = tpl_adc_pkg::CAPTURE_RUN;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= tpl_adc_pkg::CAPTURE_RUN;
    end else begin
      state <= state_next;
    end
  end

  // The converter reset is held for as long as the capture waits for sync
  assign adc_sync_status = (state == tpl_adc_pkg::CAPTURE_ARMED);
  assign adc_rst_sync    = (state == tpl_adc_pkg::CAPTURE_ARMED);

  // ********************
  // Valid alignment
  // ********************

  // Two stages cover the deframer and the channel formatter
  // The output valid uses the state that holds after the same edge, so it is low while armed
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_d1  <= 1'b0;
      valid_d2  <= 1'b0;
      adc_valid <= '0;
    end else begin
      valid_d1  <= link_valid;
      valid_d2  <= valid_d1;
      adc_valid <= {`TPL_NUM_CHANNELS{valid_d2 && (state_next == tpl_adc_pkg::CAPTURE_RUN)}};
    end
  end

  // Data moves in step with the gated valid
  always_ff @(posedge clk) begin
    adc_data <= fmt_data;
  end

endmodule

`default_nettype wire

// ==== tpl_channel.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "tpl_adc_defs.svh"

module tpl_channel (
  input  wire                     clk,
  input  wire                     arst_n,
  input  wire                     link_valid,
  input  tpl_adc_pkg::raw_group_t raw_data,
  input  wire                     dfmt_enable,
  input  wire                     dfmt_sign_extend,
  input  wire                     dfmt_type,
  input  tpl_adc_pkg::pn_sel_t    pn_seq_sel,
  output tpl_adc_pkg::fmt_group_t fmt_data,
  output logic                    pn_err,
  output logic                    pn_oos
);

  localparam int RES = `TPL_CONVERTER_RESOLUTION;
  localparam int DMA = `TPL_DMA_BITS_PER_SAMPLE;
  localparam int PAD = DMA - RES;

  tpl_adc_pkg::fmt_group_t fmt_next;

  // ********************
  // Sample formatting
  // ********************

  for (genvar s = 0; s < `TPL_SAMPLES_PER_BEAT; s++) begin : g_fmt
    tpl_adc_pkg::raw_sample_t smp;
    tpl_adc_pkg::raw_sample_t conv;
    logic [DMA-1:0]           word;

    assign smp = raw_data[s*RES +: RES];

    // Offset binary turns into two's complement by flipping the MSB
    assign conv = dfmt_type ? smp : {~smp[RES-1], smp[RES-2:0]};

    always_comb begin
      if (!dfmt_enable) begin
        word = {{PAD{1'b0}}, smp};
      end else if (dfmt_sign_extend) begin
        word = {{PAD{conv[RES-1]}}, conv};
      end else begin
        word = {{PAD{1'b0}}, conv};
      end
    end

    assign fmt_next[s*DMA +: DMA] = word;
  end

  // Formatted samples leave one cycle after the raw ones arrive
  always_ff @(posedge clk) begin
    fmt_data <= fmt_next;
  end

  // ********************
  // Test pattern monitor
  // ********************

  // The monitor sees the raw samples, before any format change
  tpl_pn_monitor i_pn_monitor (
    .clk        (clk),
    .arst_n     (arst_n),
    .link_valid (link_valid),
    .raw_data   (raw_data),
    .pn_seq_sel (pn_seq_sel),
    .pn_err     (pn_err),
    .pn_oos     (pn_oos)
  );

endmodule

`default_nettype wire

// ==== tpl_deframer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "tpl_adc_defs.svh"

module tpl_deframer (
  input  wire                     clk,
  input  wire                     arst_n,
  input  tpl_adc_pkg::link_beat_t link_data,
  output logic [`TPL_NUM_CHANNELS*$bits(tpl_adc_pkg::raw_group_t)-1:0] raw_data
);

  // Bits of one lane word and of one sample word on the link
  localparam int LANE_BITS = $bits(tpl_adc_pkg::lane_word_t);
  localparam int WORD_BITS = LANE_BITS / `TPL_SAMPLES_PER_BEAT;
  localparam int RES       = `TPL_CONVERTER_RESOLUTION;
  localparam int GROUP_BITS = $bits(tpl_adc_pkg::raw_group_t);

  // Unpacked samples before the register stage
  logic [`TPL_NUM_CHANNELS*GROUP_BITS-1:0] raw_next;

  // ********************
  // Lane unpacking
  // ********************

  // Lane c carries channel c, so every lane unpacks into its own group
  for (genvar c = 0; c < `TPL_NUM_CHANNELS; c++) begin : g_lane
    tpl_adc_pkg::lane_word_t lane;

    assign lane = link_data[c*LANE_BITS +: LANE_BITS];

    for (genvar s = 0; s < `TPL_SAMPLES_PER_BEAT; s++) begin : g_sample
      logic [WORD_BITS-1:0] word;

      // The first octet on the wire is the high octet of the sample
      assign word = {lane[s*WORD_BITS +: 8], lane[s*WORD_BITS+8 +: 8]};

      // The converter sample sits in the top bits and the tail is dropped
      assign raw_next[c*GROUP_BITS + s*RES +: RES] = word[WORD_BITS-1 -: RES];
    end
  end

  // ********************
  // Register stage
  // ********************

  // All lanes move through the same single register stage
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      raw_data <= '0;
    end else begin
      raw_data <= raw_next;
    end
  end

endmodule

`default_nettype wire

// ==== tpl_pn_monitor.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "tpl_adc_defs.svh"

module tpl_pn_monitor (
  input  wire                     clk,
  input  wire                     arst_n,
  input  wire                     link_valid,
  input  tpl_adc_pkg::raw_group_t raw_data,
  input  tpl_adc_pkg::pn_sel_t    pn_seq_sel,
  output logic                    pn_err,
  output logic                    pn_oos
);

  localparam int RES = `TPL_CONVERTER_RESOLUTION;
  localparam int SPB = `TPL_SAMPLES_PER_BEAT;

  // Selector codes understood by the monitor
  localparam tpl_adc_pkg::pn_sel_t PN_SEL_PN9  = 4'd0;
  localparam tpl_adc_pkg::pn_sel_t PN_SEL_RAMP = 4'd1;

  // Counter widths for the lock and loss thresholds
  localparam int LOCK_W = $clog2(`TPL_PN_LOCK_COUNT);
  localparam int LOSS_W = $clog2(`TPL_PN_LOSS_COUNT);

  // Next PN9 sample after an LFSR load with the low 9 bits of the previous one
  function automatic tpl_adc_pkg::raw_sample_t pn9_next(input tpl_adc_pkg::raw_sample_t prev);
    logic [8:0] lfsr;
    logic fb;
    tpl_adc_pkg::raw_sample_t res;
    lfsr = prev[8:0];
    res = '0;
    // Bit 8 is nine bits back and bit 4 five bits back, matching x^9+x^5+1
    for (int i = RES - 1; i >= 0; i--) begin
      fb = lfsr[8] ^ lfsr[4];
      res[i] = fb;
      lfsr = {lfsr[7:0], fb};
    end
    return res;
  endfunction

  tpl_adc_pkg::pn_state_t   state;
  tpl_adc_pkg::pn_state_t   state_next;
  tpl_adc_pkg::raw_sample_t prev_sample;
  logic [LOCK_W-1:0]        good_cnt;
  logic [LOCK_W-1:0]        good_next;
  logic [LOSS_W-1:0]        bad_cnt;
  logic [LOSS_W-1:0]        bad_next;
  logic [SPB-1:0]           pair_ok;
  logic                     check_on;

  // Previous sample followed by this beat, so pair s compares entry s with entry s+1
  logic [(SPB+1)*RES-1:0] chain;

  assign check_on = (pn_seq_sel == PN_SEL_PN9) || (pn_seq_sel == PN_SEL_RAMP);
  assign chain    = {raw_data, prev_sample};

  // ********************
  // Pair comparison
  // ********************

  for (genvar s = 0; s < SPB; s++) begin : g_pair
    tpl_adc_pkg::raw_sample_t ref_sample;
    tpl_adc_pkg::raw_sample_t expected;

    assign ref_sample = chain[s*RES +: RES];
    assign expected   = (pn_seq_sel == PN_SEL_RAMP) ? ref_sample + 1'b1 : pn9_next(ref_sample);
    assign pair_ok[s] = (expected == chain[(s+1)*RES +: RES]);
  end

  // Pairs are walked in sample order so a lock can happen in the middle of a beat
  always_comb begin
    state_next = state;
    good_next  = good_cnt;
    bad_next   = bad_cnt;
    if (!check_on) begin
      state_next = tpl_adc_pkg::PN_OOS;
      good_next  = '0;
      bad_next   = '0;
    end else if (link_valid) begin
      for (int s = 0; s < SPB; s++) begin
        if (pair_ok[s]) begin
          bad_next = '0;
          if (state_next == tpl_adc_pkg::PN_OOS) begin
            if (good_next == LOCK_W'(`TPL_PN_LOCK_COUNT - 1)) begin
              state_next = tpl_adc_pkg::PN_LOCKED;
              good_next  = '0;
            end else begin
              good_next = good_next + 1'b1;
            end
          end
        end else begin
          good_next = '0;
          if (state_next == tpl_adc_pkg::PN_LOCKED) begin
            if (bad_next == LOSS_W'(`TPL_PN_LOSS_COUNT - 1)) begin
              state_next = tpl_adc_pkg::PN_OOS;
              bad_next   = '0;
            end else begin
              bad_next = bad_next + 1'b1;
            end
          end
        end
      end
    end
  end

  // ********************
  // State registers
  // ********************

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state       <= tpl_adc_pkg::PN_OOS;
      good_cnt    <= '0;
      bad_cnt     <= '0;
      prev_sample <= '0;
      pn_err      <= 1'b0;
    end else begin
      state    <= state_next;
      good_cnt <= good_next;
      bad_cnt  <= bad_next;
      // Only the last sample of a valid beat seeds the next beat
      if (link_valid) begin
        prev_sample <= raw_data[(SPB-1)*RES +: RES];
      end
      // An error is flagged only against a pattern that was already locked
      pn_err <= link_valid && check_on && (state == tpl_adc_pkg::PN_LOCKED) && !(&pair_ok);
    end
  end

  assign pn_oos = (state == tpl_adc_pkg::PN_OOS);

endmodule

`default_nettype wire
